/* cpu_pkg.sv */
////////////////////////////////////////////////////////////
// CPU shared definitions
// Word and register index types, opcode constants, the
// bubble word and the two-format instruction view
////////////////////////////////////////////////////////////
package cpu_pkg;

   // Data and address word
   typedef logic [15:0] word_t;

   // Register file index
   typedef logic [2:0] reg_idx_t;

   // Major opcode, top five bits of every instruction
   typedef logic [4:0] opcode_t;

   // Fixed opcodes
   localparam opcode_t OPC_HALT = 5'b00000;
   localparam opcode_t OPC_NOP  = 5'b00001;

   // Opcode prefixes for control-flow classes
   localparam logic [2:0] JUMP_CLASS   = 3'b001;
   localparam logic [2:0] BRANCH_CLASS = 3'b011;

   // NOP sent down the pipe in place of a real instruction
   localparam word_t BUBBLE_WORD = {OPC_NOP, 11'd0};

   // Register format, two sources
   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      logic [4:0] func;
   } r_fmt_t;

   // Immediate format, one source and a destination
   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rs;
      reg_idx_t   rd;
      logic [4:0] imm;
   } i_fmt_t;

   // Same 16 bits seen through either format
   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
   } instr_u;

endpackage

/* data_port.sv */
////////////////////////////////////////////////////////////
// Data access port
// External load/store requests run as single Wishbone cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module data_port
   import cpu_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  d_req,
   input  logic  d_we,
   input  word_t d_addr,
   input  word_t d_wdata,
   wb_if.master  bus,
   output word_t d_rdata,
   output logic  d_done
);

   logic  busy_q;
   logic  done_q;
   logic  we_q;
   word_t adr_q;
   word_t wdat_q;

   // Busy flag and completion pulse
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         done_q <= 1'b0;
      end else begin
         done_q <= busy_q & bus.ack;
         if (busy_q && bus.ack) begin
            busy_q <= 1'b0;
         end else if (!busy_q && d_req) begin
            // Requests while busy are dropped
            busy_q <= 1'b1;
         end
      end
   end

   // Request latch and read data capture
   always_ff @(posedge clk) begin
      if (!busy_q && d_req) begin
         we_q   <= d_we;
         adr_q  <= d_addr;
         wdat_q <= d_wdata;
      end
      if (busy_q && bus.ack) begin
         d_rdata <= bus.dat_r;
      end
   end

   assign bus.cyc   = busy_q;
   assign bus.stb   = busy_q;
   assign bus.we    = we_q;
   assign bus.adr   = adr_q;
   assign bus.dat_w = wdat_q;

   assign d_done = done_q;

endmodule

/* fetch_top.sv */
////////////////////////////////////////////////////////////
// Fetch subsystem top
// Fetch and data masters share one memory via the arbiter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_top
   import cpu_pkg::*;
#(
   parameter int RAW_DEPTH  = 3,
   parameter int HALT_DRAIN = 4,
   parameter int MEM_WORDS  = 256,
   parameter int MEM_WAIT   = 1
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     fetch_en,
   input  logic     redirect,
   input  word_t    jump_pc,
   input  reg_idx_t dst,
   input  logic     dst_valid,
   input  logic     d_req,
   input  logic     d_we,
   input  word_t    d_addr,
   input  word_t    d_wdata,
   output word_t    instr,
   output logic     instr_valid,
   output word_t    incr_pc,
   output logic     halt,
   output word_t    d_rdata,
   output logic     d_done
);

   // Master-side and slave-side buses
   wb_if fetch_bus ();
   wb_if data_bus ();
   wb_if mem_bus ();

   fetch_unit #(
      .RAW_DEPTH  (RAW_DEPTH),
      .HALT_DRAIN (HALT_DRAIN)
   ) fetch_unit_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_en    (fetch_en),
      .redirect    (redirect),
      .jump_pc     (jump_pc),
      .dst         (dst),
      .dst_valid   (dst_valid),
      .bus         (fetch_bus),
      .instr       (instr),
      .instr_valid (instr_valid),
      .incr_pc     (incr_pc),
      .halt        (halt)
   );

   data_port data_port_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .d_req   (d_req),
      .d_we    (d_we),
      .d_addr  (d_addr),
      .d_wdata (d_wdata),
      .bus     (data_bus),
      .d_rdata (d_rdata),
      .d_done  (d_done)
   );

   wb_arbiter wb_arbiter_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .m_fetch (fetch_bus),
      .m_data  (data_bus),
      .s_mem   (mem_bus)
   );

   unified_mem #(
      .MEM_WORDS (MEM_WORDS),
      .MEM_WAIT  (MEM_WAIT)
   ) unified_mem_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mem_bus)
   );

endmodule

/* fetch_unit.sv */
////////////////////////////////////////////////////////////
// Fetch unit
// Reads instructions over Wishbone, issues one word or a
// bubble per slot, stalls on RAW, jump/branch and halt
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_unit
   import cpu_pkg::*;
#(
   parameter int RAW_DEPTH  = 3,
   parameter int HALT_DRAIN = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     fetch_en,
   input  logic     redirect,
   input  word_t    jump_pc,
   input  reg_idx_t dst,
   input  logic     dst_valid,
   wb_if.master     bus,
   output word_t    instr,
   output logic     instr_valid,
   output word_t    incr_pc,
   output logic     halt
);

   localparam int DW = $clog2(HALT_DRAIN + 1);

   // Run, wait for redirect, drain before halt
   typedef enum logic [1:0] {M_RUN, M_WAIT, M_DRAIN} mode_e;

   mode_e          mode_q;
   word_t          pc_q;
   word_t          pc_p2;
   logic           rd_q;
   logic           have_q;
   word_t          word_q;
   instr_u         cur;
   logic           cur_ok;
   opcode_t        opc;
   logic           rs_v;
   logic           rt_v;
   logic           raw;
   logic           run_slot;
   logic           stall_slot;
   logic           slot;
   logic           issue;
   logic [DW-1:0]  drain_cnt;
   logic           halt_q;
   logic           valid_q;

   assign pc_p2 = pc_q + 16'd2;

   // Word in hand, or the one arriving with ack
   assign cur    = have_q ? word_q : bus.dat_r;
   assign cur_ok = have_q | (rd_q & bus.ack);
   assign opc    = cur.i_fmt.opcode;

   // rs unused for 000xx and 001x0, rt only for 1101x and 111xx
   assign rs_v = (opc[4:2] != 3'b000) && ({opc[4:2], opc[0]} != 4'b0010);
   assign rt_v = (opc[4:1] == 4'b1101) || (opc[4:2] == 3'b111);

   raw_detector #(
      .RAW_DEPTH (RAW_DEPTH)
   ) raw_detector_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .src1      (cur.r_fmt.rs),
      .src2      (cur.r_fmt.rt),
      .src1_v    (rs_v),
      .src2_v    (rt_v),
      .dst       (dst),
      .dst_valid (dst_valid),
      .slot      (slot),
      .raw       (raw)
   );

   // Slot types
   assign run_slot   = fetch_en & (mode_q == M_RUN) & cur_ok;
   assign stall_slot = fetch_en & (mode_q != M_RUN) & ~halt_q;
   assign slot       = run_slot | stall_slot;
   // Real word goes out only when hazard free
   assign issue      = run_slot & ~raw;

   ////////////////////////////////////////////////////////////
   // Control state
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mode_q    <= M_RUN;
         pc_q      <= '0;
         rd_q      <= 1'b0;
         have_q    <= 1'b0;
         drain_cnt <= '0;
         halt_q    <= 1'b0;
         valid_q   <= 1'b0;
      end else begin
         valid_q <= slot;

         // Bus read, one word at a time
         if (rd_q && bus.ack) begin
            rd_q   <= 1'b0;
            have_q <= 1'b1;
         end else if (!rd_q && !have_q && fetch_en && (mode_q == M_RUN)) begin
            rd_q <= 1'b1;
         end

         // Issue consumes the word
         if (issue) begin
            have_q <= 1'b0;
            if (opc == OPC_HALT) begin
               // PC parks on the halt
               mode_q    <= M_DRAIN;
               drain_cnt <= DW'(HALT_DRAIN);
            end else if ((opc[4:2] == JUMP_CLASS) || (opc[4:2] == BRANCH_CLASS)) begin
               mode_q <= M_WAIT;
            end else begin
               pc_q <= pc_p2;
            end
         end

         // Redirect releases the jump/branch hold
         if ((mode_q == M_WAIT) && redirect) begin
            pc_q   <= jump_pc;
            mode_q <= M_RUN;
         end

         // Halt rises with the last drain bubble
         if (stall_slot && (mode_q == M_DRAIN)) begin
            drain_cnt <= drain_cnt - 1'b1;
            if (drain_cnt == DW'(1)) begin
               halt_q <= 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Payload
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rd_q && bus.ack) begin
         word_q <= bus.dat_r;
      end
      if (slot) begin
         instr <= issue ? word_t'(cur) : BUBBLE_WORD;
      end
      // Bubbles leave incr_pc alone
      if (issue) begin
         incr_pc <= pc_p2;
      end
   end

   // Read-only master
   assign bus.cyc   = rd_q;
   assign bus.stb   = rd_q;
   assign bus.we    = 1'b0;
   assign bus.adr   = pc_q;
   assign bus.dat_w = '0;

   assign instr_valid = valid_q;
   assign halt        = halt_q;

endmodule

/* raw_detector.sv */
////////////////////////////////////////////////////////////
// RAW hazard detector
// Shift history of in-flight destinations, compared against
// the sources of the word about to issue
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module raw_detector
   import cpu_pkg::*;
#(
   parameter int RAW_DEPTH = 3
) (
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t src1,
   input  reg_idx_t src2,
   input  logic     src1_v,
   input  logic     src2_v,
   input  reg_idx_t dst,
   input  logic     dst_valid,
   input  logic     slot,
   output logic     raw
);

   // History, entry 0 is the newest
   reg_idx_t               hist_dst [RAW_DEPTH];
   logic [RAW_DEPTH-1:0]   hist_v;

   // Valid bits shift once per issue slot
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hist_v <= '0;
      end else if (slot) begin
         for (int i = RAW_DEPTH - 1; i > 0; i--) begin
            hist_v[i] <= hist_v[i-1];
         end
         // Empty entry when nothing reported this slot
         hist_v[0] <= dst_valid;
      end
   end

   // Destination indices follow the same shift
   always_ff @(posedge clk) begin
      if (slot) begin
         for (int i = RAW_DEPTH - 1; i > 0; i--) begin
            hist_dst[i] <= hist_dst[i-1];
         end
         hist_dst[0] <= dst;
      end
   end

   // Any valid source hitting any valid entry
   always_comb begin
      raw = 1'b0;
      for (int i = 0; i < RAW_DEPTH; i++) begin
         if (hist_v[i] && ((src1_v && (hist_dst[i] == src1)) ||
                           (src2_v && (hist_dst[i] == src2)))) begin
            raw = 1'b1;
         end
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, pass decided from the log
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_fetch_top -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 ||
echo "build or simulation did not complete"
grep -q "PASS: all tests" sim.log && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}

/* tb_checker.sv */
////////////////////////////////////////////////////////////
// Fetch subsystem checker
// Models memory contents, PC and issue rules, and compares
// every DUT slot and data-port result against the model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_checker
   import cpu_pkg::*;
#(
   parameter int RAW_DEPTH  = 3,
   parameter int HALT_DRAIN = 4
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     fetch_en,
   input  logic     redirect,
   input  word_t    jump_pc,
   input  reg_idx_t dst,
   input  logic     dst_valid,
   input  logic     d_req,
   input  logic     d_we,
   input  word_t    d_addr,
   input  word_t    d_wdata,
   input  word_t    instr,
   input  logic     instr_valid,
   input  word_t    incr_pc,
   input  logic     halt,
   input  word_t    d_rdata,
   input  logic     d_done,
   input  logic     end_check,
   input  int       expect_issued
);

   typedef enum logic [1:0] {C_RUN, C_WAIT, C_DRAIN} cmode_e;

   // Memory image built from data-port writes
   word_t  mem_model [256];
   int     errors  = 0;
   int     issued  = 0;
   int     haz_bub = 0;
   int     drain_n = 0;
   cmode_e mode;
   word_t  pc_m;
   logic   halt_exp;
   logic   fe_prev;
   logic   pend;
   logic   pend_we;
   word_t  pend_adr;

   // Reported destinations, entry 0 is the newest
   reg_idx_t             h_dst [RAW_DEPTH];
   logic [RAW_DEPTH-1:0] h_v;
   reg_idx_t             dst_prev;
   logic                 dv_prev;
   logic                 redir_seen;
   word_t                redir_tgt;

   task automatic value_error(input string name, input word_t exp, input word_t act);
      $display("ERROR %s expected 0x%04h actual 0x%04h", name, exp, act);
      errors++;
   endtask

   task automatic rule_error(input string msg);
      $display("Checker failure: %s", msg);
      errors++;
   endtask

   // Does word w read register r through rs or rt
   function automatic logic reads_reg(input word_t w, input reg_idx_t r);
      logic rs_used;
      logic rt_used;
      rs_used = (w[15:13] != 3'b000) && ({w[15:13], w[11]} != 4'b0010);
      rt_used = (w[15:12] == 4'b1101) || (w[15:13] == 3'b111);
      return (rs_used && (w[10:8] == r)) || (rt_used && (w[7:5] == r));
   endfunction

   // Any valid history entry feeding word w
   function automatic logic hazard_for(input word_t w);
      logic hit;
      hit = 1'b0;
      for (int k = 0; k < RAW_DEPTH; k++) begin
         if (h_v[k] && reads_reg(w, h_dst[k])) hit = 1'b1;
      end
      return hit;
   endfunction

   // One slot ages the history
   task automatic shift_history();
      for (int k = RAW_DEPTH - 1; k > 0; k--) begin
         h_dst[k] = h_dst[k-1];
         h_v[k]   = h_v[k-1];
      end
      h_dst[0] = dst_prev;
      h_v[0]   = dv_prev;
   endtask

   ////////////////////////////////////////////////////////////
   // One issue slot
   ////////////////////////////////////////////////////////////
   task automatic check_slot();
      word_t exp_w;
      logic  bubble;
      bubble = (instr === BUBBLE_WORD);
      if (mode == C_RUN) begin
         exp_w = mem_model[pc_m[8:1]];
         if (hazard_for(exp_w)) begin
            // Word held behind an in-flight destination
            if (!bubble) value_error("instr", BUBBLE_WORD, instr);
            haz_bub++;
         end else begin
            if (instr !== exp_w) begin
               value_error("instr", exp_w, instr);
            end else begin
               issued++;
            end
            if (incr_pc !== pc_m + 16'd2) value_error("incr_pc", pc_m + 16'd2, incr_pc);
            if (exp_w[15:11] == OPC_HALT) begin
               mode    = C_DRAIN;
               drain_n = 0;
            end else if (exp_w[15:13] == JUMP_CLASS || exp_w[15:13] == BRANCH_CLASS) begin
               mode = C_WAIT;
            end else begin
               pc_m = pc_m + 16'd2;
            end
         end
      end else begin
         if (!bubble) value_error("instr", BUBBLE_WORD, instr);
         if (mode == C_DRAIN) begin
            drain_n++;
            if (drain_n == HALT_DRAIN) halt_exp = 1'b1;
            if (drain_n > HALT_DRAIN) rule_error("issue slot after halt");
         end
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         mode       = C_RUN;
         pc_m       = '0;
         halt_exp   = 1'b0;
         fe_prev    = 1'b0;
         pend       = 1'b0;
         pend_we    = 1'b0;
         pend_adr   = '0;
         drain_n    = 0;
         h_v        = '0;
         dst_prev   = '0;
         dv_prev    = 1'b0;
         redir_seen = 1'b0;
         redir_tgt  = '0;
      end else begin
         // Data port completion
         if (d_done) begin
            if (!pend) begin
               rule_error("d_done pulsed without a request");
            end else if (!pend_we && d_rdata !== mem_model[pend_adr[8:1]]) begin
               value_error("d_rdata", mem_model[pend_adr[8:1]], d_rdata);
            end
            pend = 1'b0;
         end
         if (d_req) begin
            pend     = 1'b1;
            pend_we  = d_we;
            pend_adr = d_addr;
            if (d_we) mem_model[d_addr[8:1]] = d_wdata;
         end

         if (instr_valid) begin
            if (!fe_prev) rule_error("instr_valid while fetch was disabled");
            check_slot();
            // Bubbles age the history too
            shift_history();
         end

         // Redirect sampled one cycle ago
         // Its edge still carried a hold bubble
         if (redir_seen) begin
            pc_m = redir_tgt;
            mode = C_RUN;
         end
         redir_seen = (mode == C_WAIT) && redirect;
         redir_tgt  = jump_pc;

         if (halt !== halt_exp) value_error("halt", word_t'(halt_exp), word_t'(halt));

         if (end_check) begin
            if (issued != expect_issued) begin
               value_error("issued_count", word_t'(expect_issued), word_t'(issued));
            end
            if (haz_bub < 1) rule_error("no bubble seen before the hazard word");
            if (!halt_exp) rule_error("halt never reached");
         end
         fe_prev  = fetch_en;
         dst_prev = dst;
         dv_prev  = dst_valid;
      end
   end

endmodule

/* tb_fetch_top.sv */
////////////////////////////////////////////////////////////
// Fetch subsystem testbench
// Loads a program through the data port, then runs fetch
// with hazard, jump, branch and halt stimulus
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_fetch_top
   import cpu_pkg::*;
();

   localparam int RAW_DEPTH  = 3;
   localparam int HALT_DRAIN = 4;
   localparam int N_PROG     = 10;
   localparam int TIMEOUT    = 200;

   logic     clk;
   logic     rst_n;
   logic     fetch_en;
   logic     redirect;
   word_t    jump_pc;
   reg_idx_t dst;
   logic     dst_valid;
   logic     d_req;
   logic     d_we;
   word_t    d_addr;
   word_t    d_wdata;
   word_t    instr;
   logic     instr_valid;
   word_t    incr_pc;
   logic     halt;
   word_t    d_rdata;
   logic     d_done;
   logic     end_check;
   int       tb_errors = 0;
   int       seed      = 32007;

   // Program table, address and word
   word_t prog_addr [N_PROG];
   word_t prog_word [N_PROG];
   // Redirect table, control word and its target
   word_t redir_after [2];
   word_t redir_pc    [2];

   fetch_top #(
      .RAW_DEPTH  (RAW_DEPTH),
      .HALT_DRAIN (HALT_DRAIN)
   ) fetch_top_i (
      .clk (clk), .rst_n (rst_n), .fetch_en (fetch_en), .redirect (redirect),
      .jump_pc (jump_pc), .dst (dst), .dst_valid (dst_valid), .d_req (d_req),
      .d_we (d_we), .d_addr (d_addr), .d_wdata (d_wdata), .instr (instr),
      .instr_valid (instr_valid), .incr_pc (incr_pc), .halt (halt),
      .d_rdata (d_rdata), .d_done (d_done)
   );

   tb_checker #(
      .RAW_DEPTH  (RAW_DEPTH),
      .HALT_DRAIN (HALT_DRAIN)
   ) chk_i (
      .clk (clk), .rst_n (rst_n), .fetch_en (fetch_en), .redirect (redirect),
      .jump_pc (jump_pc), .dst (dst), .dst_valid (dst_valid), .d_req (d_req),
      .d_we (d_we), .d_addr (d_addr), .d_wdata (d_wdata), .instr (instr),
      .instr_valid (instr_valid), .incr_pc (incr_pc), .halt (halt),
      .d_rdata (d_rdata), .d_done (d_done), .end_check (end_check),
      .expect_issued (N_PROG)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Random word outside the halt, jump and branch classes
   function automatic word_t filler();
      word_t w;
      w = word_t'($random(seed));
      if (w[15:13] == 3'b000 || w[15:13] == 3'b001 || w[15:13] == 3'b011) w[15] = 1'b1;
      return w;
   endfunction

   task automatic timeout_error(input string what);
      $display("Timeout while waiting for %s", what);
      tb_errors++;
   endtask

   task automatic wait_done();
      int n;
      for (n = 0; n < TIMEOUT; n++) begin
         @(posedge clk);
         #2;
         if (d_done) break;
      end
      if (n == TIMEOUT) timeout_error("d_done");
   endtask

   task automatic data_access(input logic we, input word_t addr, input word_t data);
      d_req   = 1'b1;
      d_we    = we;
      d_addr  = addr;
      d_wdata = data;
      @(posedge clk);
      #2;
      d_req = 1'b0;
      wait_done();
   endtask

   // Any slot when match is off, else a slot carrying word w
   task automatic wait_slot(input logic match, input word_t w);
      int n;
      for (n = 0; n < TIMEOUT; n++) begin
         @(posedge clk);
         #2;
         if (instr_valid && (!match || instr == w)) break;
      end
      if (n == TIMEOUT) timeout_error("an issue slot");
   endtask

   task automatic wait_halt();
      int n;
      for (n = 0; n < TIMEOUT; n++) begin
         @(posedge clk);
         #2;
         if (halt) break;
      end
      if (n == TIMEOUT) timeout_error("halt");
   endtask

   initial begin
      int i;
      int total;
      fetch_en  = 1'b0;
      redirect  = 1'b0;
      jump_pc   = '0;
      dst       = '0;
      dst_valid = 1'b0;
      d_req     = 1'b0;
      d_we      = 1'b0;
      d_addr    = '0;
      d_wdata   = '0;
      end_check = 1'b0;
      rst_n     = 1'b0;

      prog_addr = '{16'h00, 16'h02, 16'h04, 16'h06, 16'h08, 16'h0A,
                    16'h20, 16'h22, 16'h40, 16'h42};
      for (i = 0; i < N_PROG; i++) prog_word[i] = filler();
      // Hazard word reads r5, then jump, branch and halt
      prog_word[4] = 16'h8500;
      prog_word[5] = 16'h2123;
      prog_word[7] = 16'h6045;
      prog_word[9] = 16'h0012;
      redir_after  = '{16'h2123, 16'h6045};
      redir_pc     = '{16'h0020, 16'h0040};

      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      // Idle with fetch off
      repeat (4) @(posedge clk);
      #2;

      ////////////////////////////////////////////////////////////
      // Program load and readback
      ////////////////////////////////////////////////////////////
      for (i = 0; i < N_PROG; i++) data_access(1'b1, prog_addr[i], prog_word[i]);
      for (i = 0; i < N_PROG; i++) data_access(1'b0, prog_addr[i], 16'h0000);

      fetch_en = 1'b1;
      // Data read competing with fetch
      data_access(1'b0, 16'h0022, 16'h0000);

      // Report r5 in the slot before the hazard word
      wait_slot(1'b1, prog_word[2]);
      dst       = 3'd5;
      dst_valid = 1'b1;
      wait_slot(1'b0, 16'h0000);
      dst_valid = 1'b0;

      for (i = 0; i < 2; i++) begin
         wait_slot(1'b1, redir_after[i]);
         wait_slot(1'b1, BUBBLE_WORD);
         wait_slot(1'b1, BUBBLE_WORD);
         redirect = 1'b1;
         jump_pc  = redir_pc[i];
         @(posedge clk);
         #2;
         redirect = 1'b0;
      end

      wait_halt();
      repeat (8) @(posedge clk);
      #2;
      end_check = 1'b1;
      @(posedge clk);
      #2;
      end_check = 1'b0;
      repeat (2) @(posedge clk);

      total = tb_errors + chk_i.errors;
      $display("Error count %0d (checker %0d, testbench %0d)", total, chk_i.errors, tb_errors);
      if (total == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* unified_mem.sv */
////////////////////////////////////////////////////////////
// Unified word memory
// Wishbone slave, ack after a fixed number of wait states
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module unified_mem
   import cpu_pkg::*;
#(
   parameter int MEM_WORDS = 256,
   parameter int MEM_WAIT  = 1
) (
   input  logic clk,
   input  logic rst_n,
   wb_if.slave  bus
);

   localparam int AW = $clog2(MEM_WORDS);
   localparam int WW = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

   word_t          mem [MEM_WORDS];
   logic [AW-1:0]  idx;
   logic [WW-1:0]  wcnt;
   logic           ack_q;

   // Byte address, bit 0 dropped
   assign idx = bus.adr[AW:1];

   // Wait-state count, ack MEM_WAIT+1 cycles after stb
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ack_q <= 1'b0;
         wcnt  <= '0;
      end else if (ack_q) begin
         // Single-cycle ack
         ack_q <= 1'b0;
         wcnt  <= '0;
      end else if (bus.cyc && bus.stb) begin
         if (wcnt == WW'(MEM_WAIT)) begin
            ack_q <= 1'b1;
            wcnt  <= '0;
         end else begin
            wcnt <= wcnt + 1'b1;
         end
      end else begin
         wcnt <= '0;
      end
   end

   // Write lands on the ack edge
   always_ff @(posedge clk) begin
      if (ack_q && bus.cyc && bus.stb && bus.we) begin
         mem[idx] <= bus.dat_w;
      end
   end

   // Read data straight from the array
   assign bus.dat_r = mem[idx];
   assign bus.ack   = ack_q;

endmodule

/* verilog.f */
cpu_pkg.sv
wb_if.sv
raw_detector.sv
fetch_unit.sv
data_port.sv
wb_arbiter.sv
unified_mem.sv
fetch_top.sv
tb_checker.sv
tb_fetch_top.sv

/* wb_arbiter.sv */
////////////////////////////////////////////////////////////
// Wishbone arbiter
// Two masters onto one slave, data master has priority,
// grant held until ack
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_arbiter (
   input  logic clk,
   input  logic rst_n,
   wb_if.slave  m_fetch,
   wb_if.slave  m_data,
   wb_if.master s_mem
);

   // Grant encoding, 1 selects the data master
   logic own_q;
   logic gnt_q;
   logic sel;

   // Locked grant while owned, else data first
   assign sel = own_q ? gnt_q : m_data.cyc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         own_q <= 1'b0;
         gnt_q <= 1'b0;
      end else if (s_mem.ack) begin
         // Transfer done, bus free next cycle
         own_q <= 1'b0;
      end else if (!own_q && s_mem.cyc) begin
         own_q <= 1'b1;
         gnt_q <= sel;
      end
   end

   // Request mux
   assign s_mem.cyc   = sel ? m_data.cyc   : m_fetch.cyc;
   assign s_mem.stb   = sel ? m_data.stb   : m_fetch.stb;
   assign s_mem.we    = sel ? m_data.we    : m_fetch.we;
   assign s_mem.adr   = sel ? m_data.adr   : m_fetch.adr;
   assign s_mem.dat_w = sel ? m_data.dat_w : m_fetch.dat_w;

   // Response only to the granted master
   // Loser sees no ack and keeps waiting
   assign m_data.ack    = s_mem.ack & sel;
   assign m_fetch.ack   = s_mem.ack & ~sel;
   assign m_data.dat_r  = sel ? s_mem.dat_r : '0;
   assign m_fetch.dat_r = sel ? '0 : s_mem.dat_r;

endmodule

/* wb_if.sv */
////////////////////////////////////////////////////////////
// Wishbone classic bus
// One master and one slave, single-word transfers
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface wb_if
   import cpu_pkg::*;
();

   // Request side
   logic  cyc;
   logic  stb;
   logic  we;
   word_t adr;
   word_t dat_w;

   // Response side, ack is a one-cycle pulse
   word_t dat_r;
   logic  ack;

   modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);

   modport slave (input cyc, stb, we, adr, dat_w, output dat_r, ack);

endinterface
